//--- bus_arbiter.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------------
// round-robin arbiter, two requesters onto one memory, response routing
// --------------------------------------------------------------------------
module bus_arbiter (
  input  logic                   clk,
  input  logic                   UART_RST,
  input  logic                   m0_valid,
  output logic                   m0_ready,
  input  uart_bus_pkg::bus_req_t m0_req,
  output logic                   m0_rsp_valid,
  input  logic                   m1_valid,
  output logic                   m1_ready,
  input  uart_bus_pkg::bus_req_t m1_req,
  output logic                   m1_rsp_valid,
  input  uart_bus_pkg::bus_rsp_t rsp_in,
  output uart_bus_pkg::bus_rsp_t rsp,
  output logic                   mem_valid,
  output uart_bus_pkg::bus_req_t mem_req
);

  logic prio_m1;    // m1 wins a tie
  logic rsp_pend;   // read granted last cycle
  logic rsp_owner;  // 1 when that read came from m1
  logic grant0;
  logic grant1;

  assign grant0 = m0_valid && (!m1_valid || !prio_m1);
  assign grant1 = m1_valid && (!m0_valid || prio_m1);

  assign m0_ready  = grant0;
  assign m1_ready  = grant1;
  assign mem_valid = grant0 || grant1;
  assign mem_req   = grant1 ? m1_req : m0_req;

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      prio_m1   <= 1'b0;
      rsp_pend  <= 1'b0;
      rsp_owner <= 1'b0;
    end else begin
      rsp_pend <= mem_valid && !mem_req.wr;
      if (mem_valid) begin
        prio_m1   <= grant0;  // the other side goes first next time
        rsp_owner <= grant1;
      end
    end
  end

  // read data is shared, only the valid is steered
  assign m0_rsp_valid = rsp_pend && !rsp_owner;
  assign m1_rsp_valid = rsp_pend && rsp_owner;
  assign rsp          = rsp_in;

endmodule

//--- bus_mem.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------------
// byte memory, writes on the grant cycle, read data one cycle later
// --------------------------------------------------------------------------
module bus_mem #(
  parameter int ADDR_W = 8
) (
  input  logic                   clk,
  input  logic                   mem_valid,
  input  uart_bus_pkg::bus_req_t mem_req,
  output uart_bus_pkg::bus_rsp_t rsp
);

  logic [7:0]        mem [2**ADDR_W];
  logic [ADDR_W-1:0] idx;

  assign idx = mem_req.addr[ADDR_W-1:0];  // upper address bits wrap

  always_ff @(posedge clk) begin
    if (mem_valid) begin
      if (mem_req.wr) begin
        mem[idx] <= mem_req.wdata;
      end else begin
        rsp.rdata <= mem[idx];
      end
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# compile with verilator, run, then look for the pass message in the log
verilator --binary --timing --assert --top-module tb_uart_bus -f vlog.f > build.log 2>&1 &&
  ./obj_dir/Vtb_uart_bus > sim.log 2>&1 ||
  { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Test completed successfully" sim.log && echo "PASS" ||
  { echo "FAIL, see sim.log"; exit 1; }

//--- tb_uart_bus.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------------
// directed testbench, serial driver and monitor, host port tasks,
// compare tasks and watchdog
// --------------------------------------------------------------------------
module tb_uart_bus;

  import uart_bus_pkg::*;

  localparam int ADDR_W   = 8;
  localparam int MEM_SIZE = 2**ADDR_W;
  localparam int len_wr   = 8;   // block lengths of the tests
  localparam int len_rd   = 6;
  localparam int len_wrap = 5;
  localparam int len_mix  = 10;
  // serial frames in both directions over all tests
  localparam int frame_total = 5 + (18 + len_wr) + (18 + len_rd) + 7
                             + (18 + len_wrap) + (18 + len_mix);
  localparam int watchdog_cycles = frame_total * 40 * 2 + MEM_SIZE * 4 + 2000;

  logic     clk = 1'b0;
  logic     UART_RST;
  logic     rx;
  logic     tx;
  logic     host_valid;
  logic     host_ready;
  bus_req_t host_req;
  logic     host_rsp_valid;
  bus_rsp_t host_rsp;

  logic [7:0] model [MEM_SIZE];   // expected memory contents
  logic [7:0] tx_q [$];           // bytes decoded from tx
  int         mismatch_count = 0;
  int         other_count = 0;
  integer     seed;

  uart_bus_top #(
    .ADDR_W (ADDR_W)
  ) i_uart_bus_top (
    .clk            (clk),
    .UART_RST       (UART_RST),
    .rx             (rx),
    .tx             (tx),
    .host_valid     (host_valid),
    .host_ready     (host_ready),
    .host_req       (host_req),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp       (host_rsp)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired, run did not finish within %0d cycles", watchdog_cycles);
    $display("Test failed");
    $finish;
  end

  // tx decoder, samples in the middle of each bit
  initial begin : tx_monitor
    logic [7:0] b;
    forever begin
      @(negedge clk);
      if (tx === 1'b0) begin
        repeat (2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (4) @(negedge clk);
          b = {tx, b[7:1]};  // lsb first
        end
        repeat (4) @(negedge clk);
        if (tx !== 1'b1) begin
          other_count++;
          $display("tx frame with a low stop bit, byte dropped");
        end else begin
          tx_q.push_back(b);
        end
      end
    end
  end

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic logic [ADDR_W-1:0] wrap_idx(input logic [31:0] a);
    return a[ADDR_W-1:0];
  endfunction

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      mismatch_count++;
      $display("mismatch %s: expected %02h, actual %02h", name, exp, act);
    end
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    if (act !== exp) begin
      mismatch_count++;
      $display("mismatch %s: expected %02h, actual %02h", name, exp.rdata, act.rdata);
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};  // stop, data, start
    @(negedge clk);
    for (int i = 0; i < 10; i++) begin
      rx = frame[0];
      frame = frame >> 1;
      repeat (4) @(negedge clk);
    end
  endtask

  task automatic wait_tx_bytes(input int n);
    int cycles;
    cycles = 0;
    while (tx_q.size() < n && cycles < n * 60 + 100) begin
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic pop_check(input string name, input logic [7:0] exp);
    if (tx_q.size() == 0) begin
      other_count++;
      $display("%s: serial byte %02h never arrived on tx", name, exp);
    end else begin
      check_byte(name, exp, tx_q.pop_front());
    end
  endtask

  task automatic expect_ack(input string name);
    wait_tx_bytes(3);
    pop_check(name, ack_word[0]);
    pop_check(name, ack_word[1]);
    pop_check(name, ack_word[2]);
  endtask

  task automatic set_length(input string name, input int len);
    logic [15:0] l;
    l = len[15:0];
    send_byte(cmd_len);
    send_byte(l[7:0]);  // low byte first
    send_byte(l[15:8]);
    expect_ack(name);
  endtask

  task automatic set_address(input string name, input logic [31:0] addr);
    send_byte(cmd_addr);
    send_byte(addr[7:0]);
    send_byte(addr[15:8]);
    send_byte(addr[23:16]);
    send_byte(addr[31:24]);
    expect_ack(name);
  endtask

  task automatic write_block_serial(input string name, input logic [31:0] addr, input int len);
    logic [7:0] d;
    send_byte(cmd_write);
    for (int i = 0; i < len; i++) begin
      d = rand_byte();
      model[wrap_idx(addr + i)] = d;
      send_byte(d);
    end
    expect_ack(name);
  endtask

  task automatic read_block_serial(input string name, input logic [31:0] addr, input int len);
    send_byte(cmd_read);
    wait_tx_bytes(len + 3);
    for (int i = 0; i < len; i++) pop_check(name, model[wrap_idx(addr + i)]);
    expect_ack(name);
  endtask

  // returns on the falling edge after the handshake
  task automatic wait_grant(input string name);
    int cycles;
    cycles = 0;
    #1;
    while (!host_ready && cycles < 20) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (!host_ready) begin
      other_count++;
      $display("%s: host port was never granted the bus", name);
    end
    @(negedge clk);
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [7:0] d);
    @(negedge clk);
    host_valid     = 1'b1;
    host_req.wr    = 1'b1;
    host_req.addr  = addr;
    host_req.wdata = d;
    wait_grant("host_write");
    host_valid = 1'b0;
    model[wrap_idx(addr)] = d;
  endtask

  task automatic host_read(input string name, input logic [31:0] addr);
    bus_rsp_t exp;
    int       cycles;
    @(negedge clk);
    host_valid     = 1'b1;
    host_req.wr    = 1'b0;
    host_req.addr  = addr;
    host_req.wdata = 8'h00;
    wait_grant(name);
    host_valid = 1'b0;
    cycles = 0;
    while (!host_rsp_valid && cycles < 4) begin
      @(negedge clk);
      cycles++;
    end
    exp.rdata = model[wrap_idx(addr)];
    if (!host_rsp_valid) begin
      other_count++;
      $display("%s: no read response on the host port", name);
    end else begin
      check_rsp(name, exp, host_rsp);
    end
  endtask

  task automatic fill_memory();
    logic [31:0] a;
    for (int i = 0; i < MEM_SIZE; i++) begin
      a = i;
      host_write(a, (a[7:0] * 8'd29) ^ 8'hA7);
    end
  endtask

  task automatic read_after_reset();
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      if (tx !== 1'b1) begin
        other_count++;
        $display("read_after_reset: tx left idle after reset");
      end
    end
    fill_memory();  // length and address keep their reset values
    read_block_serial("read_after_reset", 32'h0, 1);
  endtask

  task automatic write_over_uart();
    logic [31:0] base;
    base = {24'h0, rand_byte() & 8'hF0};
    set_length("write_over_uart", len_wr);
    set_address("write_over_uart", base);
    write_block_serial("write_over_uart", base, len_wr);
    for (int i = 0; i < len_wr; i++) host_read("write_over_uart", base + i);
  endtask

  task automatic read_over_uart();
    logic [31:0] base;
    base = {24'h0, rand_byte()};
    for (int i = 0; i < len_rd; i++) host_write(base + i, rand_byte());
    set_length("read_over_uart", len_rd);
    set_address("read_over_uart", base);
    read_block_serial("read_over_uart", base, len_rd);
  endtask

  task automatic ignore_unknown_cmd();
    send_byte(8'h5A);
    repeat (3 * 40) @(negedge clk);  // room for a full acknowledge
    if (tx_q.size() != 0) begin
      other_count++;
      $display("ignore_unknown_cmd: serial output after an unknown command");
      tx_q.delete();
    end
    set_length("ignore_unknown_cmd", 3);
  endtask

  task automatic wrap_high_address();
    logic [31:0] base;
    base = 32'hC0DE_01FC;  // block crosses the top of the memory
    set_length("wrap_high_address", len_wrap);
    set_address("wrap_high_address", base);
    write_block_serial("wrap_high_address", base, len_wrap);
    for (int i = 0; i < len_wrap; i++)
      host_read("wrap_high_address", (base + i) ^ 32'h1234_5600);
  endtask

  task automatic host_during_write();
    logic [31:0] base;
    base = 32'h0000_0040;
    set_length("host_during_write", len_mix);
    set_address("host_during_write", base);
    fork
      write_block_serial("host_during_write", base, len_mix);
      begin
        for (int i = 0; i < 6; i++) begin
          repeat (37) @(negedge clk);  // drifts against the frame rate
          host_read("host_during_write", 32'h80 + i);
        end
      end
    join
    for (int i = 0; i < len_mix; i++) host_read("host_during_write", base + i);
  endtask

  initial begin
    seed       = 32'h2709_b7c8;
    UART_RST   = 1'b1;
    rx         = 1'b1;
    host_valid = 1'b0;
    host_req   = '0;
    repeat (2) @(negedge clk);
    UART_RST = 1'b0;

    read_after_reset();
    write_over_uart();
    read_over_uart();
    ignore_unknown_cmd();
    wrap_high_address();
    host_during_write();

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- uart_bus_assert.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------------
// arbiter checks, one grant at a time, stable requests, read response timing
// --------------------------------------------------------------------------
module uart_bus_assert (
  input logic                   clk,
  input logic                   UART_RST,
  input logic                   m0_valid,
  input logic                   m0_ready,
  input uart_bus_pkg::bus_req_t m0_req,
  input logic                   m0_rsp_valid,
  input logic                   m1_valid,
  input logic                   m1_ready,
  input uart_bus_pkg::bus_req_t m1_req,
  input logic                   m1_rsp_valid
);

  logic rd0;
  logic rd1;

  assign rd0 = m0_valid && m0_ready && !m0_req.wr;  // granted reads
  assign rd1 = m1_valid && m1_ready && !m1_req.wr;

  a_one_grant: assert property (@(posedge clk) disable iff (UART_RST)
    !(m0_ready && m1_ready))
    else $error("both requesters granted in one cycle");

  a_m0_hold: assert property (@(posedge clk) disable iff (UART_RST)
    m0_valid && !m0_ready |=> m0_valid && $stable(m0_req))
    else $error("m0 request dropped or changed before ready");

  a_m1_hold: assert property (@(posedge clk) disable iff (UART_RST)
    m1_valid && !m1_ready |=> m1_valid && $stable(m1_req))
    else $error("m1 request dropped or changed before ready");

  // response exactly one cycle after the read grant, never otherwise
  a_m0_rsp: assert property (@(posedge clk) disable iff (UART_RST)
    m0_rsp_valid == $past(rd0))
    else $error("m0 response not one cycle after its read grant");

  a_m1_rsp: assert property (@(posedge clk) disable iff (UART_RST)
    m1_rsp_valid == $past(rd1))
    else $error("m1 response not one cycle after its read grant");

endmodule

bind bus_arbiter uart_bus_assert i_uart_bus_assert (
  .clk          (clk),
  .UART_RST     (UART_RST),
  .m0_valid     (m0_valid),
  .m0_ready     (m0_ready),
  .m0_req       (m0_req),
  .m0_rsp_valid (m0_rsp_valid),
  .m1_valid     (m1_valid),
  .m1_ready     (m1_ready),
  .m1_req       (m1_req),
  .m1_rsp_valid (m1_rsp_valid)
);

//--- uart_bus_pkg.sv
// --------------------------------------------------------------------------
// bus request and response structs, command letters, acknowledge bytes
// --------------------------------------------------------------------------
package uart_bus_pkg;

  // one memory access from a requester
  typedef struct packed {
    logic        wr;     // 1 = write, 0 = read
    logic [31:0] addr;
    logic [7:0]  wdata;
  } bus_req_t;

  // read data, one cycle after a read grant
  typedef struct packed {
    logic [7:0] rdata;
  } bus_rsp_t;

  // ascii command letters
  localparam logic [7:0] cmd_len   = 8'h6C;  // "l"
  localparam logic [7:0] cmd_addr  = 8'h61;  // "a"
  localparam logic [7:0] cmd_write = 8'h77;  // "w"
  localparam logic [7:0] cmd_read  = 8'h72;  // "r"

  // "O", "K", carriage return
  localparam logic [0:2][7:0] ack_word = {8'h4F, 8'h4B, 8'h0D};

endpackage

//--- uart_bus_top.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------------
// serial command master and host port sharing one byte memory
// --------------------------------------------------------------------------
module uart_bus_top #(
  parameter int ADDR_W = 8
) (
  input  logic                   clk,
  input  logic                   UART_RST,
  input  logic                   rx,
  output logic                   tx,
  input  logic                   host_valid,
  output logic                   host_ready,
  input  uart_bus_pkg::bus_req_t host_req,
  output logic                   host_rsp_valid,
  output uart_bus_pkg::bus_rsp_t host_rsp
);

  import uart_bus_pkg::*;

  logic       rx_valid;
  logic [7:0] rx_byte;
  logic       tx_valid;
  logic       tx_ready;
  logic [7:0] tx_byte;

  logic     m_valid;
  logic     m_ready;
  bus_req_t m_req;
  logic     m_rsp_valid;

  logic     mem_valid;
  bus_req_t mem_req;
  bus_rsp_t mem_rsp;

  uart_byte_io i_uart_byte_io (
    .clk      (clk),
    .UART_RST (UART_RST),
    .rx       (rx),
    .tx       (tx),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_byte  (tx_byte),
    .rx_error ()
  );

  uart_master i_uart_master (
    .clk       (clk),
    .UART_RST  (UART_RST),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .tx_byte   (tx_byte),
    .req_valid (m_valid),
    .req_ready (m_ready),
    .req       (m_req),
    .rsp_valid (m_rsp_valid),
    .rsp       (host_rsp)     // read data is shared by both peers
  );

  // m0 is the serial master, m1 the host port
  bus_arbiter i_bus_arbiter (
    .clk          (clk),
    .UART_RST     (UART_RST),
    .m0_valid     (m_valid),
    .m0_ready     (m_ready),
    .m0_req       (m_req),
    .m0_rsp_valid (m_rsp_valid),
    .m1_valid     (host_valid),
    .m1_ready     (host_ready),
    .m1_req       (host_req),
    .m1_rsp_valid (host_rsp_valid),
    .rsp_in       (mem_rsp),
    .rsp          (host_rsp),
    .mem_valid    (mem_valid),
    .mem_req      (mem_req)
  );

  bus_mem #(
    .ADDR_W (ADDR_W)
  ) i_bus_mem (
    .clk       (clk),
    .mem_valid (mem_valid),
    .mem_req   (mem_req),
    .rsp       (mem_rsp)
  );

endmodule

//--- uart_byte_io.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------------
// 8N1 serial receiver and transmitter, clk at 4x the baud rate
// --------------------------------------------------------------------------
module uart_byte_io (
  input  logic       clk,
  input  logic       UART_RST,
  input  logic       rx,
  output logic       tx,
  output logic       rx_valid,
  output logic [7:0] rx_byte,
  input  logic       tx_valid,
  output logic       tx_ready,
  input  logic [7:0] tx_byte,
  output logic       rx_error
);

  // same frame phases for both directions
  typedef enum logic [1:0] {
    ph_idle,
    ph_start,
    ph_data,
    ph_stop
  } phase_t;

  logic [1:0] rx_sync;
  logic       rx_in;
  phase_t     rx_state;
  logic [1:0] rx_phase;  // cycle within the bit
  logic [2:0] rx_bits;

  phase_t     tx_state;
  logic [1:0] tx_phase;
  logic [2:0] tx_bits;
  logic [7:0] tx_shift;

  assign rx_in    = rx_sync[1];
  assign tx_ready = (tx_state == ph_idle);

  // receiver
  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      rx_sync  <= 2'b11;
      rx_state <= ph_idle;
      rx_phase <= '0;
      rx_bits  <= '0;
      rx_valid <= 1'b0;
      rx_error <= 1'b0;
    end else begin
      rx_sync  <= {rx_sync[0], rx};
      rx_valid <= 1'b0;
      rx_error <= 1'b0;
      rx_phase <= rx_phase + 2'd1;
      case (rx_state)
        ph_idle: begin
          rx_phase <= '0;
          if (!rx_in) rx_state <= ph_start;  // falling edge of start bit
        end
        ph_start: begin
          // two cycles in, close to the middle of the start bit
          if (rx_phase == 2'd1) begin
            rx_phase <= '0;
            rx_bits  <= '0;
            rx_state <= rx_in ? ph_idle : ph_data;  // high again: glitch
          end
        end
        ph_data: begin
          if (rx_phase == 2'd3) begin
            rx_bits <= rx_bits + 3'd1;
            if (rx_bits == 3'd7) rx_state <= ph_stop;
          end
        end
        ph_stop: begin
          if (rx_phase == 2'd3) begin
            rx_state <= ph_idle;
            rx_valid <= rx_in;
            rx_error <= !rx_in;  // framing error, byte dropped
          end
        end
        default: rx_state <= ph_idle;
      endcase
    end
  end

  // data bits come in lsb first
  always_ff @(posedge clk) begin
    if (rx_state == ph_data && rx_phase == 2'd3) rx_byte <= {rx_in, rx_byte[7:1]};
  end

  // transmitter
  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      tx_state <= ph_idle;
      tx_phase <= '0;
      tx_bits  <= '0;
      tx       <= 1'b1;
    end else begin
      tx_phase <= tx_phase + 2'd1;
      case (tx_state)
        ph_idle: begin
          tx_phase <= '0;
          if (tx_valid) begin
            tx       <= 1'b0;  // start bit from the next cycle
            tx_state <= ph_start;
          end
        end
        ph_start: begin
          if (tx_phase == 2'd3) begin
            tx       <= tx_shift[0];
            tx_bits  <= '0;
            tx_state <= ph_data;
          end
        end
        ph_data: begin
          if (tx_phase == 2'd3) begin
            tx_bits <= tx_bits + 3'd1;
            if (tx_bits == 3'd7) begin
              tx       <= 1'b1;
              tx_state <= ph_stop;
            end else begin
              tx <= tx_shift[1];
            end
          end
        end
        ph_stop: begin
          if (tx_phase == 2'd3) tx_state <= ph_idle;
        end
        default: tx_state <= ph_idle;
      endcase
    end
  end

  // bit 0 of the shifter is always the bit on the line
  always_ff @(posedge clk) begin
    if (tx_valid && tx_ready) tx_shift <= tx_byte;
    else if (tx_state == ph_data && tx_phase == 2'd3) tx_shift <= {1'b0, tx_shift[7:1]};
  end

endmodule

//--- uart_master.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------------
// command decoder, serial bytes to bus requests, read data and acknowledge
// --------------------------------------------------------------------------
module uart_master (
  input  logic                   clk,
  input  logic                   UART_RST,
  input  logic                   rx_valid,
  input  logic [7:0]             rx_byte,
  output logic                   tx_valid,
  input  logic                   tx_ready,
  output logic [7:0]             tx_byte,
  output logic                   req_valid,
  input  logic                   req_ready,
  output uart_bus_pkg::bus_req_t req,
  input  logic                   rsp_valid,
  input  uart_bus_pkg::bus_rsp_t rsp
);

  import uart_bus_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_set_len,
    st_set_addr,
    st_write,
    st_read,
    st_ack
  } state_t;

  state_t      state;
  logic [15:0] cnt;        // byte index within the command
  logic [15:0] blk_len;
  logic [31:0] base_addr;
  logic        rd_wait;    // read granted, data due next cycle
  logic [31:0] cur_addr;
  logic        last_byte;
  logic        wr_issue;
  logic        rd_issue;
  logic        rd_take;
  logic        ack_load;

  assign cur_addr  = base_addr + {16'd0, cnt};
  assign last_byte = (cnt == blk_len - 16'd1);
  assign wr_issue  = (state == st_write) && !req_valid && rx_valid;
  assign rd_issue  = (state == st_read) && !req_valid && !rd_wait && !tx_valid;
  assign rd_take   = (state == st_read) && rd_wait && rsp_valid;
  assign ack_load  = (state == st_ack) && !tx_valid;

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      state     <= st_idle;
      cnt       <= '0;
      blk_len   <= 16'd1;
      base_addr <= '0;
      rd_wait   <= 1'b0;
      req_valid <= 1'b0;
      tx_valid  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          cnt <= '0;
          if (rx_valid) begin
            case (rx_byte)
              cmd_len:   state <= st_set_len;
              cmd_addr:  state <= st_set_addr;
              cmd_write: state <= (blk_len == 16'd0) ? st_ack : st_write;
              cmd_read:  state <= (blk_len == 16'd0) ? st_ack : st_read;
              default:   state <= st_idle;  // anything else is ignored
            endcase
          end
        end
        st_set_len: begin
          if (rx_valid) begin
            if (cnt[0]) begin
              blk_len[15:8] <= rx_byte;
              cnt           <= '0;
              state         <= st_ack;
            end else begin
              blk_len[7:0] <= rx_byte;  // low byte first
              cnt          <= cnt + 16'd1;
            end
          end
        end
        st_set_addr: begin
          if (rx_valid) begin
            base_addr[{cnt[1:0], 3'b000} +: 8] <= rx_byte;
            if (cnt[1:0] == 2'd3) begin
              cnt   <= '0;
              state <= st_ack;
            end else begin
              cnt <= cnt + 16'd1;
            end
          end
        end
        st_write: begin
          if (wr_issue) begin
            req_valid <= 1'b1;
          end else if (req_valid && req_ready) begin
            req_valid <= 1'b0;
            cnt       <= last_byte ? 16'd0 : cnt + 16'd1;
            if (last_byte) state <= st_ack;
          end
        end
        st_read: begin
          // request, wait for data, hand it to the transmitter
          if (rd_issue) begin
            req_valid <= 1'b1;
          end else if (req_valid && req_ready) begin
            req_valid <= 1'b0;
            rd_wait   <= 1'b1;
          end else if (rd_take) begin
            rd_wait  <= 1'b0;
            tx_valid <= 1'b1;
          end else if (tx_valid && tx_ready) begin
            tx_valid <= 1'b0;
            cnt      <= last_byte ? 16'd0 : cnt + 16'd1;
            if (last_byte) state <= st_ack;
          end
        end
        st_ack: begin
          if (ack_load) begin
            tx_valid <= 1'b1;
          end else if (tx_ready) begin
            tx_valid <= 1'b0;
            cnt      <= (cnt == 16'd2) ? 16'd0 : cnt + 16'd1;
            if (cnt == 16'd2) state <= st_idle;  // CR sent
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_issue) begin
      req.wr    <= 1'b1;
      req.addr  <= cur_addr;
      req.wdata <= rx_byte;
    end else if (rd_issue) begin
      req.wr    <= 1'b0;
      req.addr  <= cur_addr;
      req.wdata <= '0;
    end
    if (rd_take) tx_byte <= rsp.rdata;
    else if (ack_load) tx_byte <= ack_word[cnt[1:0]];
  end

endmodule

//--- vlog.f
uart_bus_pkg.sv
uart_byte_io.sv
uart_master.sv
bus_arbiter.sv
bus_mem.sv
uart_bus_top.sv
uart_bus_assert.sv
tb_uart_bus.sv
